// File: list.f
rtl/microrocPkg.sv
rtl/slowControlLoader.sv
rtl/daqSequencer.sv
rtl/ramReadOut.sv
rtl/microrocTop.sv
tests/asicModel.sv
tests/microrocTb.sv

// File: rtl/daqSequencer.sv
`timescale 1ns/1ps

module daqSequencer #(
   parameter int PowerUpCycles = microrocPkg::PowerUpCyclesDefault // pwrOn to startAcq, >= 1
) (
   input  logic                  Clk,
   input  logic                  reset,          // Sync, active high
   input  logic                  acqReq,         // Host request, four-phase
   input  microrocPkg::acqTime_t acqTime,        // Window length, latched on request
   input  logic                  chipSatB,       // Chip memory full, active low
   input  logic                  endReadout,     // One-cycle pulse from the chip
   output logic                  acqAck,
   output logic                  pwrOn,          // Merged power pulsing line
   output logic                  startAcq,       // Acquisition window
   output logic                  startReadout,   // RAM readout request to chip
   output logic                  readoutOpen     // Gates the deserializer
);

   microrocPkg::daqState_t state;
   microrocPkg::acqTime_t  cycleCount;           // Shared by power-up and window
   microrocPkg::acqTime_t  acqTimeReg;           // Window length for this run

   assign readoutOpen = (state == microrocPkg::DaqReadout);

   ////////////////////////////////////////
   // Window length latch
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (state == microrocPkg::DaqIdle && acqReq) begin
         acqTimeReg <= acqTime;
      end
   end

   ////////////////////////////////////////
   // Sequencing FSM
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (reset) begin
         state        <= microrocPkg::DaqIdle;
         cycleCount   <= '0;
         acqAck       <= 1'b0;
         pwrOn        <= 1'b0;
         startAcq     <= 1'b0;
         startReadout <= 1'b0;
      end else begin
         case (state)
            microrocPkg::DaqIdle: begin
               if (acqReq) begin                          // Ack is low in idle
                  pwrOn      <= 1'b1;
                  cycleCount <= '0;
                  state      <= microrocPkg::DaqPowerUp;
               end
            end

            microrocPkg::DaqPowerUp: begin
               if (cycleCount == microrocPkg::acqTime_t'(PowerUpCycles - 1)) begin
                  startAcq   <= 1'b1;                     // Supplies settled
                  cycleCount <= '0;
                  state      <= microrocPkg::DaqAcquire;
               end else begin
                  cycleCount <= cycleCount + 1'b1;
               end
            end

            microrocPkg::DaqAcquire: begin
               // Window closes on length reached or chip full
               // A zero length behaves as a single cycle
               if (cycleCount + 16'd1 >= acqTimeReg || !chipSatB) begin
                  startAcq     <= 1'b0;
                  startReadout <= 1'b1;
                  state        <= microrocPkg::DaqReadout;
               end else begin
                  cycleCount <= cycleCount + 1'b1;
               end
            end

            microrocPkg::DaqReadout: begin
               if (endReadout) begin                      // Chip RAM emptied
                  startReadout <= 1'b0;
                  state        <= microrocPkg::DaqPowerDown;
               end
            end

            microrocPkg::DaqPowerDown: begin
               pwrOn <= 1'b0;                             // Power pulsing off
               state <= microrocPkg::DaqDone;
            end

            microrocPkg::DaqDone: begin
               if (!acqAck) begin
                  acqAck <= 1'b1;                         // One cycle after pwrOn drops
               end else if (!acqReq) begin
                  acqAck <= 1'b0;                         // Phase four
                  state  <= microrocPkg::DaqIdle;
               end
            end

            default: begin
               state <= microrocPkg::DaqIdle;
            end
         endcase
      end
   end

endmodule

// File: rtl/microrocPkg.sv
package microrocPkg;

   ////////////////////////////////////////
   // Data widths
   ////////////////////////////////////////

   typedef logic [15:0] readWord_t;     // One packed readout word
   typedef logic [15:0] acqTime_t;      // Acquisition window in Clk cycles
   typedef logic [7:0]  dropCount_t;    // Saturating lost-word count

   ////////////////////////////////////////
   // FSM encodings
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      LoadIdle,                         // Waiting for configReq
      LoadReset,                        // srRstb pulse, one cycle
      LoadShift,                        // Two cycles per bit
      LoadDone                          // Ack held until req drops
   } loaderState_t;

   typedef enum logic [2:0] {
      DaqIdle,                          // Power off, waiting for acqReq
      DaqPowerUp,                       // pwrOn high, settling
      DaqAcquire,                       // startAcq window
      DaqReadout,                       // Waiting for endReadout
      DaqPowerDown,                     // One cycle before pwrOn drops
      DaqDone                           // Ack phase of the handshake
   } daqState_t;

   ////////////////////////////////////////
   // Defaults for the top level
   ////////////////////////////////////////

   localparam int ConfigBitsDefault    = 32;  // Real chip has 592
   localparam int PowerUpCyclesDefault = 8;   // pwrOn to startAcq

endpackage

// File: rtl/microrocTop.sv
`timescale 1ns/1ps

module microrocTop #(
   parameter int ConfigBits    = microrocPkg::ConfigBitsDefault,    // Slow control width
   parameter int PowerUpCycles = microrocPkg::PowerUpCyclesDefault  // pwrOn to startAcq
) (
   input  logic                    Clk,
   input  logic                    reset,         // Sync, active high
   // Host, configuration handshake
   input  logic                    configReq,
   input  logic [ConfigBits-1:0]   configWord,
   output logic                    configAck,
   // Host, acquisition handshake
   input  logic                    acqReq,
   input  microrocPkg::acqTime_t   acqTime,
   output logic                    acqAck,
   // Slow control pins
   output logic                    select,
   output logic                    srRstb,
   output logic                    srCk,
   output logic                    srIn,
   // DAQ control pins
   output logic                    pwrOn,
   output logic                    startAcq,
   output logic                    startReadout,
   input  logic                    chipSatB,
   input  logic                    endReadout,
   // RAM readout pins
   input  logic                    doutB,
   input  logic                    transmitOnB,
   // External FIFO side
   input  logic                    fifoFull,
   output microrocPkg::readWord_t  dataWord,
   output logic                    dataValid,
   output microrocPkg::dropCount_t dropCount
);

   logic readoutOpen;                             // Sequencer readout phase

   ////////////////////////////////////////
   // Execute side
   ////////////////////////////////////////

   slowControlLoader #(
      .ConfigBits (ConfigBits)
   ) i_loader (
      .Clk        (Clk),
      .reset      (reset),
      .configReq  (configReq),
      .configWord (configWord),
      .configAck  (configAck),
      .select     (select),
      .srRstb     (srRstb),
      .srCk       (srCk),
      .srIn       (srIn)
   );

   daqSequencer #(
      .PowerUpCycles (PowerUpCycles)
   ) i_sequencer (
      .Clk          (Clk),
      .reset        (reset),
      .acqReq       (acqReq),
      .acqTime      (acqTime),
      .chipSatB     (chipSatB),
      .endReadout   (endReadout),
      .acqAck       (acqAck),
      .pwrOn        (pwrOn),
      .startAcq     (startAcq),
      .startReadout (startReadout),
      .readoutOpen  (readoutOpen)
   );

   ////////////////////////////////////////
   // Result side
   ////////////////////////////////////////

   ramReadOut i_ramReadOut (
      .Clk         (Clk),
      .reset       (reset),
      .readoutOpen (readoutOpen),
      .doutB       (doutB),
      .transmitOnB (transmitOnB),
      .fifoFull    (fifoFull),
      .dataWord    (dataWord),
      .dataValid   (dataValid),
      .dropCount   (dropCount)
   );

endmodule

// File: rtl/ramReadOut.sv
`timescale 1ns/1ps

module ramReadOut (
   input  logic                    Clk,
   input  logic                    reset,        // Sync, active high
   input  logic                    readoutOpen,  // From sequencer, readout phase
   input  logic                    doutB,        // Serial data, active low
   input  logic                    transmitOnB,  // Data on doutB valid, active low
   input  logic                    fifoFull,     // External FIFO cannot take a word
   output microrocPkg::readWord_t  dataWord,     // Packed word, MSB first on the wire
   output logic                    dataValid,    // One-cycle write strobe
   output microrocPkg::dropCount_t dropCount     // Words lost to a full FIFO
);

   logic [14:0] shiftReg;                        // First 15 bits of a word
   logic [3:0]  bitCount;                        // Bits gathered so far
   logic        wordPending;                     // Word on dataWord this cycle
   logic        sampleEn;                        // Bit present on doutB

   assign sampleEn  = readoutOpen && !transmitOnB;

   // Stream cannot stall, so a full FIFO blocks the strobe directly
   assign dataValid = wordPending && !fifoFull;

   ////////////////////////////////////////
   // Deserializer
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (sampleEn) begin
         shiftReg <= {shiftReg[13:0], ~doutB};   // Invert the active-low data
      end
   end

   always_ff @(posedge Clk) begin
      if (sampleEn && bitCount == 4'd15) begin
         dataWord <= {shiftReg, ~doutB};         // 16th bit completes the word
      end
   end

   always_ff @(posedge Clk) begin
      if (reset) begin
         bitCount    <= '0;
         wordPending <= 1'b0;
      end else begin
         wordPending <= sampleEn && bitCount == 4'd15;
         if (!readoutOpen) begin
            bitCount <= '0;                      // Drop a partial word
         end else if (sampleEn) begin
            bitCount <= bitCount + 1'b1;         // Wraps after bit 16
         end
      end
   end

   ////////////////////////////////////////
   // Drop counter
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (reset) begin
         dropCount <= '0;
      end else if (wordPending && fifoFull && dropCount != 8'hff) begin
         dropCount <= dropCount + 1'b1;          // Saturates at 255
      end
   end

endmodule

// File: rtl/slowControlLoader.sv
`timescale 1ns/1ps

module slowControlLoader #(
   parameter int ConfigBits = microrocPkg::ConfigBitsDefault // Slow control word width, >= 2
) (
   input  logic                  Clk,
   input  logic                  reset,        // Sync, active high
   input  logic                  configReq,    // Host request, four-phase
   input  logic [ConfigBits-1:0] configWord,   // Stable while configReq is high
   output logic                  configAck,    // Held until configReq drops
   output logic                  select,       // Slow control register selected
   output logic                  srRstb,       // Register reset, active low
   output logic                  srCk,         // Half-rate shift clock
   output logic                  srIn          // Serial data, MSB first
);

   localparam int CountWidth = $clog2(ConfigBits);

   microrocPkg::loaderState_t state;
   logic [ConfigBits-1:0]     shiftReg;        // Bits still to send, MSB on top
   logic [CountWidth-1:0]     bitCount;        // Index of bit on srIn

   ////////////////////////////////////////
   // Shift register
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (state == microrocPkg::LoadIdle && configReq) begin
         shiftReg <= configWord;                          // Latch on request
      end else if (state == microrocPkg::LoadShift && srCk) begin
         shiftReg <= shiftReg << 1;                       // Next bit to MSB
      end
   end

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (reset) begin
         state     <= microrocPkg::LoadIdle;
         bitCount  <= '0;
         configAck <= 1'b0;
         select    <= 1'b0;
         srRstb    <= 1'b1;                               // Inactive high
         srCk      <= 1'b0;
         srIn      <= 1'b0;
      end else begin
         case (state)
            microrocPkg::LoadIdle: begin
               // Ack is always low here, so the request can be taken
               if (configReq) begin
                  select   <= 1'b1;
                  srRstb   <= 1'b0;                       // Clear chip register
                  bitCount <= '0;
                  state    <= microrocPkg::LoadReset;
               end
            end

            microrocPkg::LoadReset: begin
               srRstb <= 1'b1;                            // One-cycle reset pulse
               srCk   <= 1'b0;
               srIn   <= shiftReg[ConfigBits-1];          // First bit, MSB
               state  <= microrocPkg::LoadShift;
            end

            microrocPkg::LoadShift: begin
               if (!srCk) begin
                  srCk <= 1'b1;                           // Chip captures here
               end else if (bitCount == CountWidth'(ConfigBits - 1)) begin
                  srCk      <= 1'b0;
                  srIn      <= 1'b0;
                  select    <= 1'b0;                      // Release the register
                  configAck <= 1'b1;
                  state     <= microrocPkg::LoadDone;
               end else begin
                  srCk     <= 1'b0;
                  srIn     <= shiftReg[ConfigBits-2];     // Change while clock low
                  bitCount <= bitCount + 1'b1;
               end
            end

            microrocPkg::LoadDone: begin
               if (!configReq) begin
                  configAck <= 1'b0;                      // Phase four
                  state     <= microrocPkg::LoadIdle;
               end
            end

            default: begin
               state <= microrocPkg::LoadIdle;
            end
         endcase
      end
   end

endmodule

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module microrocTb \
      -f list.f --Mdir obj_dir -o simMicroroc; then
   echo "Verilator build failed"
   exit 1
fi

simOutput=$(./obj_dir/simMicroroc 2>&1)
simStatus=$?
echo "$simOutput"
if [ "$simStatus" -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "TEST PASSED" <<< "$simOutput"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tests/asicModel.sv
`timescale 1ns/1ps

module asicModel #(
   parameter int ConfigBits = 32,                     // Slow control width
   parameter int MaxWords   = 6                       // Readout words per run, at most
) (
   input  logic                   Clk,
   input  logic                   select,
   input  logic                   srRstb,
   input  logic                   srCk,
   input  logic                   srIn,
   input  logic                   startAcq,
   input  logic                   startReadout,
   input  int                     satAfter,           // Cycles to memory full, 0 is never
   input  int                     wordCount,
   input  logic [MaxWords*16-1:0] readWords,          // Word w at bits [16w +: 16]
   input  logic [MaxWords-1:0]    fullMask,           // FIFO full for word w
   output logic [ConfigBits-1:0]  capturedConfig,
   output logic                   chipSatB,
   output logic                   endReadout,
   output logic                   doutB,
   output logic                   transmitOnB,
   output logic                   fifoFull
);

   logic srCkLast;                                    // srCk seen one cycle earlier

   ////////////////////////////////////////
   // Slow control register
   ////////////////////////////////////////

   always @(posedge Clk) begin
      #2;
      if (!srRstb) begin
         capturedConfig <= '0;                         // Chip register cleared
      end else if (select && srCk && !srCkLast) begin
         capturedConfig <= {capturedConfig[ConfigBits-2:0], srIn}; // Rising srCk
      end
      srCkLast <= srCk;
   end

   ////////////////////////////////////////
   // Saturation and RAM readout
   ////////////////////////////////////////

   initial begin
      int satCount;
      chipSatB    = 1'b1;
      endReadout  = 1'b0;
      doutB       = 1'b1;                             // Idle level of active-low data
      transmitOnB = 1'b1;
      fifoFull    = 1'b0;
      forever begin
         @(posedge Clk);
         #2;
         if (startAcq) begin
            satCount = 0;
            while (startAcq && satCount < 70000) begin
               if (satAfter != 0 && satCount == satAfter) begin
                  chipSatB = 1'b0;                    // Memory full
               end
               @(posedge Clk);
               #2;
               satCount++;
            end
            chipSatB = 1'b1;
            for (int i = 0; i < 4 && !startReadout; i++) begin
               @(posedge Clk);
               #2;
            end
            if (startReadout) begin
               for (int w = 0; w < wordCount; w++) begin
                  for (int b = 15; b >= 0; b--) begin
                     doutB       = ~readWords[w*16 + b]; // MSB first, inverted
                     transmitOnB = 1'b0;
                     if (b == 0) begin
                        fifoFull = fullMask[w];       // Spans the write cycle of word w
                     end
                     @(posedge Clk);
                     #2;
                  end
               end
               doutB       = 1'b1;
               transmitOnB = 1'b1;
               endReadout  = 1'b1;                    // RAM empty
               @(posedge Clk);
               #2;
               endReadout = 1'b0;
               fifoFull   = 1'b0;
            end
         end
      end
   end

endmodule

// File: tests/microrocTb.sv
`timescale 1ns/1ps

module microrocTb;

   localparam int ConfigBits    = 32;
   localparam int PowerUpCycles = 8;
   localparam int MaxWords      = 6;
   localparam int NumRows       = 6;
   localparam int SatRuns       = 42;                 // Extra fully masked runs past 255

   logic                    Clk;
   logic                    reset;
   logic                    configReq;
   logic [ConfigBits-1:0]   configWord;
   logic                    configAck;
   logic                    acqReq;
   microrocPkg::acqTime_t   acqTime;
   logic                    acqAck;
   logic                    select;                   // Slow control pins
   logic                    srRstb;
   logic                    srCk;
   logic                    srIn;
   logic                    pwrOn;                    // DAQ pins
   logic                    startAcq;
   logic                    startReadout;
   logic                    chipSatB;                 // Driven by chip model
   logic                    endReadout;
   logic                    doutB;
   logic                    transmitOnB;
   logic                    fifoFull;
   microrocPkg::readWord_t  dataWord;
   logic                    dataValid;
   microrocPkg::dropCount_t dropCount;
   logic [ConfigBits-1:0]   capturedConfig;

   logic [MaxWords*16-1:0]  modelWords;               // Current row for the chip model
   logic [MaxWords-1:0]     modelMask;
   int                      modelCount;
   int                      modelSat;

   logic [ConfigBits-1:0]   rowConfig [NumRows];
   microrocPkg::acqTime_t   rowAcqTime [NumRows];
   int                      rowSatAfter [NumRows];
   int                      rowWordCount [NumRows];
   logic [MaxWords-1:0]     rowFullMask [NumRows];
   microrocPkg::readWord_t  rowWords [NumRows][MaxWords];

   logic [31:0]             rngState;
   int                      checkCount;
   int                      checkErrors;
   int                      timeoutErrors;
   int                      totalDropped;             // Masked words so far
   int                      monitorErrors  = 0;
   int                      acqHighCycles  = 0;
   int                      powerUpCount   = 0;
   int                      powerDownCount = 0;
   logic                    windowSeen     = 1'b0;
   microrocPkg::readWord_t  capturedWords [$];

   always #10 Clk = ~Clk;                             // 20 ns period

   microrocTop #(
      .ConfigBits    (ConfigBits),
      .PowerUpCycles (PowerUpCycles)
   ) i_dut (
      .Clk (Clk), .reset (reset),
      .configReq (configReq), .configWord (configWord), .configAck (configAck),
      .acqReq (acqReq), .acqTime (acqTime), .acqAck (acqAck),
      .select (select), .srRstb (srRstb), .srCk (srCk), .srIn (srIn),
      .pwrOn (pwrOn), .startAcq (startAcq), .startReadout (startReadout),
      .chipSatB (chipSatB), .endReadout (endReadout),
      .doutB (doutB), .transmitOnB (transmitOnB),
      .fifoFull (fifoFull), .dataWord (dataWord), .dataValid (dataValid),
      .dropCount (dropCount)
   );

   asicModel #(
      .ConfigBits (ConfigBits),
      .MaxWords   (MaxWords)
   ) i_model (
      .Clk (Clk), .select (select), .srRstb (srRstb), .srCk (srCk), .srIn (srIn),
      .startAcq (startAcq), .startReadout (startReadout),
      .satAfter (modelSat), .wordCount (modelCount), .readWords (modelWords),
      .fullMask (modelMask), .capturedConfig (capturedConfig), .chipSatB (chipSatB),
      .endReadout (endReadout), .doutB (doutB), .transmitOnB (transmitOnB),
      .fifoFull (fifoFull)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic fillRow(input int idx, input int acqLen, input int satAfter,
                          input int count, input logic [MaxWords-1:0] mask);
      rngState          = xorshift32(rngState);
      rowConfig[idx]    = ConfigBits'(rngState);
      rowAcqTime[idx]   = microrocPkg::acqTime_t'(acqLen);
      rowSatAfter[idx]  = satAfter;
      rowWordCount[idx] = count;
      rowFullMask[idx]  = mask;
      for (int w = 0; w < MaxWords; w++) begin
         rngState         = xorshift32(rngState);
         rowWords[idx][w] = rngState[15:0];
      end
   endtask

   task automatic checkEqual(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      checkCount++;
      assert (got === exp) else begin
         checkErrors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic endRun();
      $display("Summary: %0d checks, %0d check errors, %0d monitor errors, %0d timeouts",
               checkCount, checkErrors, monitorErrors, timeoutErrors);
      if (checkErrors + monitorErrors + timeoutErrors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   // which is 0 for configAck, 1 for acqAck
   task automatic waitAck(input int which, input logic level, input int limit,
                          output int cycles);
      cycles = 0;
      while (((which == 0) ? configAck : acqAck) !== level && cycles < limit) begin
         @(posedge Clk);
         #2;
         cycles++;
      end
      if (((which == 0) ? configAck : acqAck) !== level) begin
         timeoutErrors++;
         $display("Timeout: %s did not go to %0b within %0d cycles",
                  (which == 0) ? "configAck" : "acqAck", level, limit);
      end
   endtask

   task automatic runConfig(input int row);
      int cycles;
      configWord = rowConfig[row];
      configReq  = 1'b1;
      waitAck(0, 1'b1, 4 * ConfigBits + 20, cycles);
      if (timeoutErrors != 0) begin
         return;
      end
      checkEqual("configAck latency", 64'(cycles), 64'(2 + 2 * ConfigBits));
      checkEqual("capturedConfig", 64'(capturedConfig), 64'(rowConfig[row]));
      checkEqual("select", 64'(select), 64'd0);
      configReq = 1'b0;
      waitAck(0, 1'b0, 4, cycles);
      if (timeoutErrors != 0) begin
         return;
      end
      checkEqual("configAck release latency", 64'(cycles), 64'd1);
   endtask

   task automatic runAcquisition(input int row);
      int cycles;
      int expHigh;
      int highBase;
      int upBase;
      int downBase;
      int wordBase;
      microrocPkg::readWord_t expWords [$];
      modelWords = '0;
      for (int w = 0; w < rowWordCount[row]; w++) begin
         modelWords[w*16 +: 16] = rowWords[row][w];
         if (rowFullMask[row][w]) begin
            totalDropped++;                           // Lost to a full FIFO
         end else begin
            expWords.push_back(rowWords[row][w]);
         end
      end
      modelCount = rowWordCount[row];
      modelSat   = rowSatAfter[row];
      modelMask  = rowFullMask[row];
      expHigh    = int'(rowAcqTime[row]);
      if (modelSat != 0 && modelSat + 1 < expHigh) begin
         expHigh = modelSat + 1;                      // Chip full ends the window
      end
      highBase = acqHighCycles;
      upBase   = powerUpCount;
      downBase = powerDownCount;
      wordBase = capturedWords.size();
      acqTime  = rowAcqTime[row];
      acqReq   = 1'b1;
      waitAck(1, 1'b1, PowerUpCycles + int'(rowAcqTime[row]) + 16 * modelCount + 40, cycles);
      if (timeoutErrors != 0) begin
         return;
      end
      checkEqual("startAcq high cycles", 64'(acqHighCycles - highBase), 64'(expHigh));
      checkEqual("pwrOn lead cycles", 64'(powerUpCount - upBase), 64'(PowerUpCycles));
      checkEqual("pwrOn tail cycles", 64'(powerDownCount - downBase), 64'd1);
      checkEqual("pwrOn", 64'(pwrOn), 64'd0);
      checkEqual("dataValid count", 64'(capturedWords.size() - wordBase), 64'(expWords.size()));
      for (int i = 0; i < expWords.size() && wordBase + i < capturedWords.size(); i++) begin
         checkEqual("dataWord", 64'(capturedWords[wordBase + i]), 64'(expWords[i]));
      end
      checkEqual("dropCount", 64'(dropCount), 64'((totalDropped > 255) ? 255 : totalDropped));
      acqReq = 1'b0;
      waitAck(1, 1'b0, 4, cycles);
      if (timeoutErrors != 0) begin
         return;
      end
      checkEqual("acqAck release latency", 64'(cycles), 64'd1);
   endtask

   ////////////////////////////////////////
   // Mid-cycle monitor
   ////////////////////////////////////////

   always @(negedge Clk) begin
      if (!reset) begin
         if (!pwrOn) begin
            windowSeen = 1'b0;                        // Between runs
         end else if (startAcq) begin
            acqHighCycles++;
            windowSeen = 1'b1;
         end else if (!windowSeen) begin
            powerUpCount++;                           // Power settling
         end else if (!startReadout) begin
            powerDownCount++;
         end
         if (dataValid) begin
            capturedWords.push_back(dataWord);
         end
         assert (!(dataValid && fifoFull)) else begin
            monitorErrors++;
            $display("dataValid was high while fifoFull was high at %0t ns", $time);
         end
         assert (pwrOn || !(startAcq || startReadout)) else begin
            monitorErrors++;
            $display("startAcq or startReadout was high with pwrOn low at %0t ns", $time);
         end
      end
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      Clk           = 1'b0;
      reset         = 1'b1;
      configReq     = 1'b0;
      configWord    = '0;
      acqReq        = 1'b0;
      acqTime       = '0;
      modelWords    = '0;
      modelMask     = '0;
      modelCount    = 0;
      modelSat      = 0;
      checkCount    = 0;
      checkErrors   = 0;
      timeoutErrors = 0;
      totalDropped  = 0;
      rngState      = 32'ha0d5071c;
      //     row acqTime satAfter words fullMask
      fillRow(0,  12,     0,      4,    6'b000000);
      fillRow(1,  20,     5,      5,    6'b000101);
      fillRow(2,   7,     0,      6,    6'b110000);
      fillRow(3,  30,     1,      3,    6'b000111);
      fillRow(4,   1,     0,      0,    6'b000000);
      fillRow(5,   3,     0,      6,    6'b111111);
      repeat (5) @(posedge Clk);
      #2;
      reset = 1'b0;
      checkEqual("select", 64'(select), 64'd0);         // All outputs inactive
      checkEqual("srRstb", 64'(srRstb), 64'd1);
      checkEqual("srCk", 64'(srCk), 64'd0);
      checkEqual("srIn", 64'(srIn), 64'd0);
      checkEqual("configAck", 64'(configAck), 64'd0);
      checkEqual("pwrOn", 64'(pwrOn), 64'd0);
      checkEqual("startAcq", 64'(startAcq), 64'd0);
      checkEqual("startReadout", 64'(startReadout), 64'd0);
      checkEqual("acqAck", 64'(acqAck), 64'd0);
      checkEqual("dataValid", 64'(dataValid), 64'd0);
      checkEqual("dropCount", 64'(dropCount), 64'd0);
      for (int row = 0; row < NumRows && timeoutErrors == 0; row++) begin
         runConfig(row);
         if (timeoutErrors == 0) begin
            runAcquisition(row);
         end
      end
      // Last row again until dropCount has to saturate
      for (int run = 0; run < SatRuns && timeoutErrors == 0; run++) begin
         runAcquisition(NumRows - 1);
      end
      endRun();
   end

endmodule
